// File: common/uart_alu_pkg.sv
package uart_alu_pkg;

    ////////////////////
    // Serial frame.
    ////////////////////

    // Baud ticks per bit on the serial line.
    localparam int OVERSAMPLE = 16;

    // Payload bits per 8N1 frame.
    localparam int DATA_BITS = 8;

    // One serial payload byte; also the ALU operand and result width.
    typedef logic [DATA_BITS-1:0] byte_t;

    ////////////////////
    // ALU opcodes.
    ////////////////////

    // MIPS-style function codes.
    // Anything not listed here makes the ALU return zero.
    typedef enum logic [7:0] {
        OP_SRL = 8'h02,   // Logical shift right.
        OP_SRA = 8'h03,   // Arithmetic shift right.
        OP_ADD = 8'h20,
        OP_SUB = 8'h22,
        OP_AND = 8'h24,
        OP_OR  = 8'h25,
        OP_XOR = 8'h26,
        OP_NOR = 8'h27
    } alu_op_e;

endpackage

// File: verilog/baud_rate_gen.sv
`timescale 1ns/1ps

module baud_rate_gen #(
    parameter int CLOCKS_PER_TICK = 163   // About 9600 baud x16 at 25 MHz.
) (
    input  logic i_clock,
    input  logic i_reset,
    output logic o_tick
);

    // A divide by one still needs a one bit counter.
    localparam int CNT_W = (CLOCKS_PER_TICK > 1) ? $clog2(CLOCKS_PER_TICK) : 1;
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(CLOCKS_PER_TICK - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else begin
            o_tick <= (count == LAST_COUNT);   // One cycle per period.
            if (count == LAST_COUNT) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // The tick is a strobe, never a level.
    a_tick_single: assert property (
        @(posedge i_clock) disable iff (!i_reset)
        (CLOCKS_PER_TICK > 1) && o_tick |=> !o_tick
    );

endmodule

// File: uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_tick,
    input  logic                i_uart_rx,
    output uart_alu_pkg::byte_t o_rx_data,
    output logic                o_rx_done
);

    localparam int TICK_W = $clog2(uart_alu_pkg::OVERSAMPLE);
    localparam int BIT_W  = $clog2(uart_alu_pkg::DATA_BITS);
    localparam logic [TICK_W-1:0] MID_TICK  = TICK_W'(uart_alu_pkg::OVERSAMPLE / 2 - 1);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(uart_alu_pkg::OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(uart_alu_pkg::DATA_BITS - 1);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_e;

    state_e              state;
    logic [TICK_W-1:0]   tick_cnt;
    logic [BIT_W-1:0]    bit_cnt;
    logic                rx_meta;
    logic                rx_sync;
    uart_alu_pkg::byte_t shift_reg;
    logic                sample_bit;
    logic                frame_ok;

    // Line is asynchronous to i_clock. Idle level is high.
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_uart_rx;
            rx_sync <= rx_meta;
        end
    end

    // Middle of a data bit, and a good stop bit.
    assign sample_bit = (state == DATA) && i_tick && (tick_cnt == LAST_TICK);
    assign frame_ok   = (state == STOP) && i_tick && (tick_cnt == LAST_TICK) && rx_sync;

    ////////////////////
    // Frame FSM.
    ////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state     <= IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            o_rx_done <= 1'b0;
        end else begin
            o_rx_done <= frame_ok;   // Low stop bit drops the frame.
            case (state)
                IDLE: begin
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    if (!rx_sync) begin
                        state <= START;
                    end
                end
                START: begin
                    if (i_tick) begin
                        if (tick_cnt == MID_TICK) begin
                            tick_cnt <= '0;
                            // Line back high by mid start bit is a glitch.
                            state    <= rx_sync ? IDLE : DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                DATA: begin
                    if (sample_bit) begin
                        tick_cnt <= '0;
                        if (bit_cnt == LAST_BIT) begin
                            state <= STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (i_tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            state <= IDLE;   // Back in time for the next start edge.
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top.
    always_ff @(posedge i_clock) begin
        if (sample_bit) begin
            shift_reg <= {rx_sync, shift_reg[uart_alu_pkg::DATA_BITS-1:1]};
        end
        if (frame_ok) begin
            o_rx_data <= shift_reg;   // Holds until the next good frame.
        end
    end

    a_done_single: assert property (
        @(posedge i_clock) disable iff (!i_reset)
        o_rx_done |=> !o_rx_done
    );

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_tick,
    input  logic                i_tx_start,
    input  uart_alu_pkg::byte_t i_tx_data,
    output logic                o_uart_tx,
    output logic                o_tx_done
);

    localparam int TICK_W = $clog2(uart_alu_pkg::OVERSAMPLE);
    localparam int BIT_W  = $clog2(uart_alu_pkg::DATA_BITS);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(uart_alu_pkg::OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(uart_alu_pkg::DATA_BITS - 1);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_e;

    state_e              state;
    logic [TICK_W-1:0]   tick_cnt;
    logic [BIT_W-1:0]    bit_cnt;
    uart_alu_pkg::byte_t shift_reg;
    logic                bit_end;

    assign bit_end = i_tick && (tick_cnt == LAST_TICK);   // Last tick of a bit time.

    ////////////////////
    // Serializer FSM.
    ////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state     <= IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            o_uart_tx <= 1'b1;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (state != IDLE && i_tick) begin
                tick_cnt <= tick_cnt + 1'b1;   // Wraps to zero on bit_end.
            end
            case (state)
                IDLE: begin
                    tick_cnt  <= '0;
                    bit_cnt   <= '0;
                    o_uart_tx <= 1'b1;
                    if (i_tx_start) begin
                        state     <= START;
                        o_uart_tx <= 1'b0;   // Start bit.
                    end
                end
                START: begin
                    if (bit_end) begin
                        state     <= DATA;
                        o_uart_tx <= shift_reg[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == LAST_BIT) begin
                            state     <= STOP;
                            o_uart_tx <= 1'b1;
                        end else begin
                            bit_cnt   <= bit_cnt + 1'b1;
                            o_uart_tx <= shift_reg[1];   // Next bit, shifted this edge.
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state     <= IDLE;
                        o_tx_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Payload. Start pulses while busy are ignored.
    always_ff @(posedge i_clock) begin
        if (state == IDLE && i_tx_start) begin
            shift_reg <= i_tx_data;
        end else if (state == DATA && bit_end) begin
            shift_reg <= {1'b0, shift_reg[uart_alu_pkg::DATA_BITS-1:1]};
        end
    end

    a_idle_high: assert property (
        @(posedge i_clock) disable iff (!i_reset)
        (state == IDLE) |-> o_uart_tx
    );

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  uart_alu_pkg::byte_t   i_data_a,
    input  uart_alu_pkg::byte_t   i_data_b,
    input  uart_alu_pkg::alu_op_e i_opcode,
    output uart_alu_pkg::byte_t   o_result
);

    // Shifts use only the low three bits of B.
    logic [2:0] shamt;

    assign shamt = i_data_b[2:0];

    always_comb begin
        case (i_opcode)
            uart_alu_pkg::OP_ADD: begin
                o_result = i_data_a + i_data_b;   // Carry out is dropped.
            end
            uart_alu_pkg::OP_SUB: begin
                o_result = i_data_a - i_data_b;
            end
            uart_alu_pkg::OP_AND: begin
                o_result = i_data_a & i_data_b;
            end
            uart_alu_pkg::OP_OR: begin
                o_result = i_data_a | i_data_b;
            end
            uart_alu_pkg::OP_XOR: begin
                o_result = i_data_a ^ i_data_b;
            end
            uart_alu_pkg::OP_NOR: begin
                o_result = ~(i_data_a | i_data_b);
            end
            uart_alu_pkg::OP_SRA: begin
                o_result = $signed(i_data_a) >>> shamt;   // Sign bit fills.
            end
            uart_alu_pkg::OP_SRL: begin
                o_result = i_data_a >> shamt;
            end
            default: begin
                o_result = '0;   // Unknown opcode.
            end
        endcase
    end

endmodule

// File: verilog/interface_circuit.sv
`timescale 1ns/1ps

module interface_circuit (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_rx_done,
    input  uart_alu_pkg::byte_t   i_rx_data,
    input  uart_alu_pkg::byte_t   i_alu_result,
    input  logic                  i_tx_done,
    output uart_alu_pkg::byte_t   o_data_a,
    output uart_alu_pkg::byte_t   o_data_b,
    output uart_alu_pkg::alu_op_e o_opcode,
    output logic                  o_tx_start,
    output uart_alu_pkg::byte_t   o_tx_data
);

    // Byte order on the line is A, opcode, B.
    typedef enum logic [2:0] {
        IDLE_A,
        GET_OP,
        GET_B,
        LAUNCH,
        WAIT_TX
    } state_e;

    state_e state;
    state_e next_state;

    ////////////////////
    // Next state.
    ////////////////////

    always_comb begin
        next_state = state;
        case (state)
            IDLE_A: begin
                if (i_rx_done) begin
                    next_state = GET_OP;
                end
            end
            GET_OP: begin
                if (i_rx_done) begin
                    next_state = GET_B;
                end
            end
            GET_B: begin
                if (i_rx_done) begin
                    next_state = LAUNCH;
                end
            end
            LAUNCH: begin
                next_state = WAIT_TX;   // B is registered, ALU result settled.
            end
            WAIT_TX: begin
                // Received bytes are dropped until the reply is out.
                if (i_tx_done) begin
                    next_state = IDLE_A;
                end
            end
            default: next_state = IDLE_A;
        endcase
    end

    ////////////////////
    // Registers.
    ////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state      <= IDLE_A;
            o_data_a   <= '0;
            o_data_b   <= '0;
            o_opcode   <= uart_alu_pkg::alu_op_e'(8'h00);
            o_tx_start <= 1'b0;
            o_tx_data  <= '0;
        end else begin
            state      <= next_state;
            o_tx_start <= 1'b0;
            case (state)
                IDLE_A: begin
                    if (i_rx_done) begin
                        o_data_a <= i_rx_data;
                    end
                end
                GET_OP: begin
                    if (i_rx_done) begin
                        o_opcode <= uart_alu_pkg::alu_op_e'(i_rx_data);   // Any value.
                    end
                end
                GET_B: begin
                    if (i_rx_done) begin
                        o_data_b <= i_rx_data;
                    end
                end
                LAUNCH: begin
                    o_tx_start <= 1'b1;
                    o_tx_data  <= i_alu_result;
                end
                default: begin
                    o_tx_start <= 1'b0;   // WAIT_TX holds everything.
                end
            endcase
        end
    end

    a_start_single: assert property (
        @(posedge i_clock) disable iff (!i_reset)
        o_tx_start |=> !o_tx_start
    );

    // The start strobe comes from LAUNCH, right after the byte for B.
    a_start_from_launch: assert property (
        @(posedge i_clock) disable iff (!i_reset)
        $rose(o_tx_start) |-> ($past(state) == LAUNCH) && $past(i_rx_done, 2)
    );

endmodule

// File: verilog/uart_alu_top.sv
`timescale 1ns/1ps

module uart_alu_top #(
    parameter int CLOCKS_PER_TICK = 163
) (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_uart_rx,
    output logic o_uart_tx
);

    logic                  tick;
    uart_alu_pkg::byte_t   rx_data;
    logic                  rx_done;
    logic                  tx_start;
    uart_alu_pkg::byte_t   tx_data;
    logic                  tx_done;
    uart_alu_pkg::byte_t   data_a;
    uart_alu_pkg::byte_t   data_b;
    uart_alu_pkg::alu_op_e opcode;
    uart_alu_pkg::byte_t   alu_result;

    baud_rate_gen #(
        .CLOCKS_PER_TICK(CLOCKS_PER_TICK)
    ) u_baud_rate_gen (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx u_uart_rx (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_tick    (tick),
        .i_uart_rx (i_uart_rx),
        .o_rx_data (rx_data),
        .o_rx_done (rx_done)
    );

    // Sequences A, opcode, B and starts the reply.
    interface_circuit u_interface_circuit (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_rx_done    (rx_done),
        .i_rx_data    (rx_data),
        .i_alu_result (alu_result),
        .i_tx_done    (tx_done),
        .o_data_a     (data_a),
        .o_data_b     (data_b),
        .o_opcode     (opcode),
        .o_tx_start   (tx_start),
        .o_tx_data    (tx_data)
    );

    alu u_alu (
        .i_data_a (data_a),
        .i_data_b (data_b),
        .i_opcode (opcode),
        .o_result (alu_result)
    );

    uart_tx u_uart_tx (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_tick     (tick),
        .i_tx_start (tx_start),
        .i_tx_data  (tx_data),
        .o_uart_tx  (o_uart_tx),
        .o_tx_done  (tx_done)
    );

endmodule

// File: verif/tb_uart_alu.sv
`timescale 1ns/1ps

module tb_uart_alu;

    localparam int CLOCK_PERIOD_NS = 40;
    localparam int CLOCKS_PER_TICK = 2;
    localparam int BIT_CLOCKS      = uart_alu_pkg::OVERSAMPLE * CLOCKS_PER_TICK;
    localparam int RANDOM_TRIPLES  = 40;
    localparam int NUM_TRIPLES     = 8 + 1 + 1 + RANDOM_TRIPLES;
    // Three request frames and one reply per triple, plus the corrupted frame.
    localparam int NUM_FRAMES      = 4 * NUM_TRIPLES + 1;
    localparam longint FRAME_NS    = 10 * BIT_CLOCKS * CLOCK_PERIOD_NS;
    localparam longint TIMEOUT_NS  = 2 * NUM_FRAMES * FRAME_NS;

    logic clock;
    logic reset;
    logic rx_line;
    logic tx_line;

    int                  error_count;
    int                  check_count;
    int                  reply_count;
    int                  expected_replies;
    uart_alu_pkg::byte_t last_reply_data;
    logic                last_reply_stop;

    uart_alu_top #(
        .CLOCKS_PER_TICK(CLOCKS_PER_TICK)
    ) u_uart_alu_top (
        .i_clock   (clock),
        .i_reset   (reset),
        .i_uart_rx (rx_line),
        .o_uart_tx (tx_line)
    );

    always #(CLOCK_PERIOD_NS / 2) clock = ~clock;

    ////////////////////
    // Checking.
    ////////////////////

    task automatic check_equal(input string name, input int expected, input int actual);
        check_count = check_count + 1;
        if (expected != actual) begin
            error_count = error_count + 1;
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // Reference ALU.
    function automatic uart_alu_pkg::byte_t alu_model(
        input uart_alu_pkg::byte_t a,
        input uart_alu_pkg::byte_t op,
        input uart_alu_pkg::byte_t b
    );
        logic [15:0] extended;
        logic [2:0]  shift;
        shift    = b[2:0];
        extended = {{8{a[7]}}, a} >> shift;   // Sign copies slide into the low byte.
        case (op)
            uart_alu_pkg::OP_ADD: return a + b;
            uart_alu_pkg::OP_SUB: return a - b;
            uart_alu_pkg::OP_AND: return a & b;
            uart_alu_pkg::OP_OR:  return a | b;
            uart_alu_pkg::OP_XOR: return a ^ b;
            uart_alu_pkg::OP_NOR: return ~(a | b);
            uart_alu_pkg::OP_SRA: return extended[7:0];
            uart_alu_pkg::OP_SRL: return a >> shift;
            default:              return 8'h00;
        endcase
    endfunction

    function automatic uart_alu_pkg::byte_t pick_op(input logic [2:0] sel);
        case (sel)
            3'd0:    return uart_alu_pkg::OP_ADD;
            3'd1:    return uart_alu_pkg::OP_SUB;
            3'd2:    return uart_alu_pkg::OP_AND;
            3'd3:    return uart_alu_pkg::OP_OR;
            3'd4:    return uart_alu_pkg::OP_XOR;
            3'd5:    return uart_alu_pkg::OP_NOR;
            3'd6:    return uart_alu_pkg::OP_SRA;
            default: return uart_alu_pkg::OP_SRL;
        endcase
    endfunction

    function automatic logic is_known_op(input uart_alu_pkg::byte_t op);
        logic known;
        known = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (op == pick_op(3'(i))) begin
                known = 1'b1;
            end
        end
        return known;
    endfunction

    ////////////////////
    // Serial driver.
    ////////////////////

    // Entered and left 1 ns after a rising edge.
    task automatic drive_bit(input logic value, input int cycles);
        rx_line = value;
        repeat (cycles) @(posedge clock);
        #1;
    endtask

    task automatic send_frame(input uart_alu_pkg::byte_t data, input logic bad_stop);
        uart_alu_pkg::byte_t bits;
        bits = data;
        @(posedge clock);
        #1;
        drive_bit(1'b0, BIT_CLOCKS);   // Start bit.
        for (int i = 0; i < uart_alu_pkg::DATA_BITS; i++) begin
            drive_bit(bits[0], BIT_CLOCKS);
            bits = bits >> 1;
        end
        if (bad_stop) begin
            // Low across the stop sample, then high again before the
            // receiver's start check, so no phantom frame follows.
            drive_bit(1'b0, BIT_CLOCKS * 3 / 4);
            drive_bit(1'b1, BIT_CLOCKS / 4 + BIT_CLOCKS);
        end else begin
            drive_bit(1'b1, BIT_CLOCKS);
        end
    endtask

    task automatic send_triple(
        input uart_alu_pkg::byte_t a,
        input uart_alu_pkg::byte_t op,
        input uart_alu_pkg::byte_t b,
        input logic corrupt
    );
        send_frame(a, 1'b0);
        if (corrupt) begin
            send_frame(8'($urandom), 1'b1);
        end
        send_frame(op, 1'b0);
        send_frame(b, 1'b0);
    endtask

    ////////////////////
    // Serial monitor.
    ////////////////////

    task automatic capture_frame(output uart_alu_pkg::byte_t data, output logic stop_bit);
        uart_alu_pkg::byte_t bits;
        bits = '0;
        @(negedge tx_line);
        repeat (BIT_CLOCKS / 2) @(negedge clock);   // Middle of the start bit.
        check_equal("reply start bit", 0, int'(tx_line));
        for (int i = 0; i < uart_alu_pkg::DATA_BITS; i++) begin
            repeat (BIT_CLOCKS) @(negedge clock);
            bits = {tx_line, bits[7:1]};   // LSB first.
        end
        repeat (BIT_CLOCKS) @(negedge clock);
        stop_bit = tx_line;
        data     = bits;
    endtask

    initial begin
        uart_alu_pkg::byte_t data;
        logic                stop_bit;
        wait (reset === 1'b1);
        forever begin
            capture_frame(data, stop_bit);
            last_reply_data = data;
            last_reply_stop = stop_bit;
            reply_count     = reply_count + 1;
        end
    end

    task automatic expect_reply(input string name, input uart_alu_pkg::byte_t expected);
        expected_replies = expected_replies + 1;
        wait (reply_count >= expected_replies);
        check_equal({name, " data"}, int'(expected), int'(last_reply_data));
        check_equal({name, " stop bit"}, 1, int'(last_reply_stop));
    endtask

    // Watchdog.
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the DUT stopped replying before all tests finished.");
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("sim failed");
        $finish;
    end

    ////////////////////
    // Tests.
    ////////////////////

    initial begin
        uart_alu_pkg::byte_t a;
        uart_alu_pkg::byte_t b;
        uart_alu_pkg::byte_t op;
        int                  low_cycles;
        void'($urandom(17));
        clock            = 1'b0;
        reset            = 1'b0;
        rx_line          = 1'b1;
        error_count      = 0;
        check_count      = 0;
        reply_count      = 0;
        expected_replies = 0;
        low_cycles       = 0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b1;

        // Quiet line after reset.
        repeat (200) begin
            @(negedge clock);
            if (tx_line !== 1'b1) begin
                low_cycles = low_cycles + 1;
            end
        end
        check_equal("idle line low cycles", 0, low_cycles);

        for (int i = 0; i < 8; i++) begin
            a  = 8'($urandom);
            b  = 8'($urandom);
            op = pick_op(3'(i));
            send_triple(a, op, b, 1'b0);
            expect_reply($sformatf("opcode 0x%02h", op), alu_model(a, op, b));
        end

        a  = 8'($urandom);
        b  = 8'($urandom);
        op = 8'($urandom);
        while (is_known_op(op)) begin
            op = 8'($urandom);
        end
        send_triple(a, op, b, 1'b0);
        expect_reply($sformatf("unknown opcode 0x%02h", op), 8'h00);

        a  = 8'($urandom);
        b  = 8'($urandom);
        op = pick_op(3'($urandom));
        send_triple(a, op, b, 1'b1);
        expect_reply("bad stop bit", alu_model(a, op, b));

        for (int i = 0; i < RANDOM_TRIPLES; i++) begin
            a  = 8'($urandom);
            b  = 8'($urandom);
            op = pick_op(3'($urandom));
            send_triple(a, op, b, 1'b0);
            expect_reply($sformatf("random %0d", i), alu_model(a, op, b));
        end

        // Room for a stray extra reply to show up.
        repeat (2 * 10 * BIT_CLOCKS) @(posedge clock);
        check_equal("reply count", expected_replies, reply_count);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: build.f
common/uart_alu_pkg.sv
verilog/baud_rate_gen.sv
uart/uart_rx.sv
uart/uart_tx.sv
verilog/alu.sv
verilog/interface_circuit.sv
verilog/uart_alu_top.sv
verif/tb_uart_alu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the serial calculator testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_uart_alu \
    -Mdir obj_dir

output=$(./obj_dir/Vtb_uart_alu)
echo "$output"

if echo "$output" | grep -q "^sim passed$"; then
    exit 0
fi
exit 1
